/* include/batch_config.svh */
`ifndef BATCH_CONFIG_SVH
`define BATCH_CONFIG_SVH

// Batch geometry
`define BATCH_DEPTH 8
`define BATCH_DSR 6

// Datapath widths
`define BATCH_ACC_W 16
`define BATCH_OUT_W 14
`define BATCH_WEIGHT_W 6

// Register defaults after reset
`define BATCH_DECAY_DEF 2
`define BATCH_WEIGHT_DEF 4

`endif

/* source/batchPkg.sv */
`include "batch_config.svh"

package batchPkg;

    // One clkDS word of stream bits
    typedef logic [`BATCH_DSR-1:0] streamWordT;

    typedef logic signed [`BATCH_WEIGHT_W-1:0] weightT;

    // Recursion state and partial results
    typedef logic signed [`BATCH_ACC_W-1:0] accT;

    // Offset binary output word
    typedef logic [`BATCH_OUT_W-1:0] outT;

    typedef logic [$clog2(`BATCH_DEPTH)-1:0] wordIdxT;

    typedef logic [2:0] shiftT;

    // Role of a batch within the three-period rotation
    typedef enum logic [1:0] {
        FILL,
        COMPUTE,
        DRAIN
    } periodT;

endpackage

/* source/batchSequencer.sv */
`timescale 1ns/1ns
`include "batch_config.svh"

module batchSequencer import batchPkg::*; (
    input  logic    clkDS,
    input  logic    rst,
    input  logic    run,
    output wordIdxT writeIdx,
    output wordIdxT fwdIdx,
    output wordIdxT bwdIdx,
    output wordIdxT resFwdIdx,
    output wordIdxT resBwdIdx,
    output wordIdxT drainIdx,
    output logic    writeBank,
    output logic    readBank,
    output logic    resBank,
    output logic    drainBank,
    output logic    computeStart,
    output logic    resWriteEn,
    output logic    outValidRaw
);

    wordIdxT cnt;
    wordIdxT cntD1, cntD2, cntD3;
    logic bank, bankD1, bankD2, bankD3;
    periodT phase;
    logic [2:0] computePipe;
    logic [3:0] drainPipe;

    // Word counter, fill bank and batch rotation
    // Held at the start of batch 0 while run is low
    always_ff @(posedge clkDS or negedge rst) begin
        if (!rst) begin
            cnt <= '0;
            bank <= 1'b0;
            phase <= FILL;
        end else if (!run) begin
            cnt <= '0;
            bank <= 1'b0;
            phase <= FILL;
        end else if (cnt == wordIdxT'(`BATCH_DEPTH - 1)) begin
            cnt <= '0;
            bank <= ~bank;
            // Oldest batch in flight moves one role ahead and stays in DRAIN
            if (phase == FILL) begin
                phase <= COMPUTE;
            end else begin
                phase <= DRAIN;
            end
        end else begin
            cnt <= cnt + 1'b1;
        end
    end

    // Delayed copies that follow the store read, lookup and recursion stages
    always_ff @(posedge clkDS or negedge rst) begin
        if (!rst) begin
            cntD1 <= '0;
            cntD2 <= '0;
            cntD3 <= '0;
            bankD1 <= 1'b0;
            bankD2 <= 1'b0;
            bankD3 <= 1'b0;
        end else begin
            cntD1 <= cnt;
            cntD2 <= cntD1;
            cntD3 <= cntD2;
            bankD1 <= bank;
            bankD2 <= bankD1;
            bankD3 <= bankD2;
        end
    end

    // Data-is-real flags that clear whenever run drops
    always_ff @(posedge clkDS or negedge rst) begin
        if (!rst) begin
            computePipe <= '0;
            drainPipe <= '0;
        end else if (!run) begin
            computePipe <= '0;
            drainPipe <= '0;
        end else begin
            computePipe <= {computePipe[1:0], phase != FILL};
            drainPipe <= {drainPipe[2:0], phase == DRAIN};
        end
    end

    assign writeIdx = cnt;
    assign writeBank = bank;

    // Compute period reads the bank filled during the previous batch
    assign fwdIdx = cnt;
    assign bwdIdx = wordIdxT'(`BATCH_DEPTH - 1 - cnt);
    assign readBank = ~bank;

    // Index 0 of a batch reaches the recursion two cycles after its read
    assign computeStart = computePipe[1] && (cntD2 == '0);

    // Results land three cycles after the read in the bank that was read
    assign resFwdIdx = cntD3;
    assign resBwdIdx = wordIdxT'(`BATCH_DEPTH - 1 - cntD3);
    assign resBank = ~bankD3;
    assign resWriteEn = computePipe[2];

    // Drain walks the results of two batches back in word order
    assign drainIdx = cntD3;
    assign drainBank = bankD3;
    assign outValidRaw = drainPipe[3] && run;

    // Drained words only while the compute pipeline is also writing results
    drainAfterCompute: assert property (@(posedge clkDS) disable iff (!rst)
        outValidRaw |-> resWriteEn);

endmodule

/* source/sampleStore.sv */
`timescale 1ns/1ns
`include "batch_config.svh"

module sampleStore import batchPkg::*; (
    input  logic       clkDS,
    input  logic       writeBank,
    input  wordIdxT    writeIdx,
    input  streamWordT inWord,
    input  logic       readBank,
    input  wordIdxT    fwdIdx,
    input  wordIdxT    bwdIdx,
    output streamWordT fwdWord,
    output streamWordT bwdWord
);

    // Two banks, one filling while the other is being read
    streamWordT mem [2][`BATCH_DEPTH];

    always_ff @(posedge clkDS) begin
        mem[writeBank][writeIdx] <= inWord;
    end

    // Forward and backward recursions read the same bank from opposite ends
    always_ff @(posedge clkDS) begin
        fwdWord <= mem[readBank][fwdIdx];
        bwdWord <= mem[readBank][bwdIdx];
    end

endmodule

/* source/coeffRegs.sv */
`timescale 1ns/1ns
`include "batch_config.svh"

module coeffRegs import batchPkg::*; (
    input  logic       clkDS,
    input  logic       rst,
    input  logic       cfgWrite,
    input  logic [2:0] cfgAddr,
    input  weightT     cfgData,
    output weightT     weights [`BATCH_DSR],
    output shiftT      decayShift
);

    // Address map: one tap weight per stream bit, then the decay shift
    always_ff @(posedge clkDS or negedge rst) begin
        if (!rst) begin
            for (int i = 0; i < `BATCH_DSR; i++) begin
                weights[i] <= weightT'(`BATCH_WEIGHT_DEF);
            end
            decayShift <= shiftT'(`BATCH_DECAY_DEF);
        end else if (cfgWrite) begin
            if (cfgAddr < `BATCH_DSR) begin
                weights[cfgAddr] <= cfgData;
            end else if (cfgAddr == `BATCH_DSR) begin
                // Low bits only
                decayShift <= cfgData[2:0];
            end
        end
    end

endmodule

/* source/tapLookup.sv */
`timescale 1ns/1ns
`include "batch_config.svh"

module tapLookup import batchPkg::*; (
    input  logic       clkDS,
    input  weightT     weights [`BATCH_DSR],
    input  streamWordT fwdWord,
    input  streamWordT bwdWord,
    output accT        fwdX,
    output accT        bwdX
);

    // Each bit adds its weight when set and subtracts it when clear
    function automatic accT weightedSum(input streamWordT word, input weightT w [`BATCH_DSR]);
        accT sum;
        sum = '0;
        for (int i = 0; i < `BATCH_DSR; i++) begin
            if (word[i]) begin
                sum = sum + accT'(w[i]);
            end else begin
                sum = sum - accT'(w[i]);
            end
        end
        return sum;
    endfunction

    accT fwdSum;
    accT bwdSum;

    assign fwdSum = weightedSum(fwdWord, weights);
    assign bwdSum = weightedSum(bwdWord, weights);

    // One register stage for both directions
    always_ff @(posedge clkDS) begin
        fwdX <= fwdSum;
        bwdX <= bwdSum;
    end

endmodule

/* source/recursionUnit.sv */
`timescale 1ns/1ns
`include "batch_config.svh"

module recursionUnit import batchPkg::*; (
    input  logic  clkDS,
    input  logic  rst,
    input  logic  computeStart,
    input  accT   x,
    input  shiftT decayShift,
    output accT   result
);

    accT prevState;
    accT leak;
    logic signed [`BATCH_ACC_W:0] nextWide;

    // Fresh start at index 0 of every batch
    assign prevState = computeStart ? '0 : result;

    // State decays by a power of two each step
    assign leak = prevState >>> decayShift;

    // One guard bit to watch for overflow
    assign nextWide = (`BATCH_ACC_W + 1)'(prevState)
        - (`BATCH_ACC_W + 1)'(leak)
        + (`BATCH_ACC_W + 1)'(x);

    always_ff @(posedge clkDS or negedge rst) begin
        if (!rst) begin
            result <= '0;
        end else begin
            result <= nextWide[`BATCH_ACC_W-1:0];
        end
    end

    // Weights and decay must keep the steady state inside the accumulator
    noWrap: assert property (@(posedge clkDS) disable iff (!rst)
        !$isunknown(nextWide) |-> (nextWide[`BATCH_ACC_W] == nextWide[`BATCH_ACC_W-1]));

endmodule

/* source/partialStore.sv */
`timescale 1ns/1ns
`include "batch_config.svh"

module partialStore import batchPkg::*; (
    input  logic    clkDS,
    input  logic    writeEn,
    input  logic    writeBank,
    input  wordIdxT writeIdx,
    input  accT     result,
    input  logic    drainBank,
    input  wordIdxT drainIdx,
    output accT     drainData
);

    // Ping-pong banks: one collects results while the other drains
    accT mem [2][`BATCH_DEPTH];

    always_ff @(posedge clkDS) begin
        if (writeEn) begin
            mem[writeBank][writeIdx] <= result;
        end
    end

    // Address arrives one cycle ahead of the combiner
    always_ff @(posedge clkDS) begin
        drainData <= mem[drainBank][drainIdx];
    end

endmodule

/* source/resultCombiner.sv */
`timescale 1ns/1ns
`include "batch_config.svh"

module resultCombiner import batchPkg::*; (
    input  logic clkDS,
    input  logic rst,
    input  accT  fwdData,
    input  accT  bwdData,
    input  logic validIn,
    output outT  outData,
    output logic outValid
);

    logic signed [`BATCH_ACC_W:0] sum;
    outT satSum;

    assign sum = (`BATCH_ACC_W + 1)'(fwdData) + (`BATCH_ACC_W + 1)'(bwdData);

    // Clamp to the signed output range
    always_comb begin
        if (sum > (2 ** (`BATCH_OUT_W - 1)) - 1) begin
            satSum = {1'b0, {(`BATCH_OUT_W - 1){1'b1}}};
        end else if (sum < -(2 ** (`BATCH_OUT_W - 1))) begin
            satSum = {1'b1, {(`BATCH_OUT_W - 1){1'b0}}};
        end else begin
            satSum = sum[`BATCH_OUT_W-1:0];
        end
    end

    // Offset binary by flipping the sign bit
    always_ff @(posedge clkDS) begin
        outData <= {~satSum[`BATCH_OUT_W-1], satSum[`BATCH_OUT_W-2:0]};
    end

    always_ff @(posedge clkDS or negedge rst) begin
        if (!rst) begin
            outValid <= 1'b0;
        end else begin
            outValid <= validIn;
        end
    end

    // Both partial stores must have been written for every drained word
    knownOut: assert property (@(posedge clkDS) disable iff (!rst)
        outValid |-> !$isunknown(outData));

endmodule

/* source/batchFilterTop.sv */
`timescale 1ns/1ns
`include "batch_config.svh"

module batchFilterTop import batchPkg::*; (
    input  logic       clkDS,
    input  logic       rst,
    input  logic       run,
    input  streamWordT inWord,
    input  logic       cfgWrite,
    input  logic [2:0] cfgAddr,
    input  weightT     cfgData,
    output outT        outData,
    output logic       outValid
);

    wordIdxT writeIdx, fwdIdx, bwdIdx, resFwdIdx, resBwdIdx, drainIdx;
    logic writeBank, readBank, resBank, drainBank;
    logic computeStart, resWriteEn, outValidRaw;
    streamWordT fwdWord, bwdWord;
    weightT weights [`BATCH_DSR];
    shiftT decayShift;
    accT fwdX, bwdX, fwdResult, bwdResult, fwdDrain, bwdDrain;

    batchSequencer sequencer (
        .clkDS(clkDS), .rst(rst), .run(run),
        .writeIdx(writeIdx), .fwdIdx(fwdIdx), .bwdIdx(bwdIdx),
        .resFwdIdx(resFwdIdx), .resBwdIdx(resBwdIdx), .drainIdx(drainIdx),
        .writeBank(writeBank), .readBank(readBank), .resBank(resBank),
        .drainBank(drainBank), .computeStart(computeStart),
        .resWriteEn(resWriteEn), .outValidRaw(outValidRaw)
    );

    sampleStore samples (
        .clkDS(clkDS), .writeBank(writeBank), .writeIdx(writeIdx), .inWord(inWord),
        .readBank(readBank), .fwdIdx(fwdIdx), .bwdIdx(bwdIdx),
        .fwdWord(fwdWord), .bwdWord(bwdWord)
    );

    coeffRegs coeffs (
        .clkDS(clkDS), .rst(rst), .cfgWrite(cfgWrite), .cfgAddr(cfgAddr),
        .cfgData(cfgData), .weights(weights), .decayShift(decayShift)
    );

    tapLookup lookup (
        .clkDS(clkDS), .weights(weights), .fwdWord(fwdWord), .bwdWord(bwdWord),
        .fwdX(fwdX), .bwdX(bwdX)
    );

    recursionUnit fwdRec (
        .clkDS(clkDS), .rst(rst), .computeStart(computeStart), .x(fwdX),
        .decayShift(decayShift), .result(fwdResult)
    );

    recursionUnit bwdRec (
        .clkDS(clkDS), .rst(rst), .computeStart(computeStart), .x(bwdX),
        .decayShift(decayShift), .result(bwdResult)
    );

    // Backward results go to their own word index so both drain in word order
    partialStore fwdStore (
        .clkDS(clkDS), .writeEn(resWriteEn), .writeBank(resBank), .writeIdx(resFwdIdx),
        .result(fwdResult), .drainBank(drainBank), .drainIdx(drainIdx),
        .drainData(fwdDrain)
    );

    partialStore bwdStore (
        .clkDS(clkDS), .writeEn(resWriteEn), .writeBank(resBank), .writeIdx(resBwdIdx),
        .result(bwdResult), .drainBank(drainBank), .drainIdx(drainIdx),
        .drainData(bwdDrain)
    );

    resultCombiner combiner (
        .clkDS(clkDS), .rst(rst), .fwdData(fwdDrain), .bwdData(bwdDrain),
        .validIn(outValidRaw), .outData(outData), .outValid(outValid)
    );

endmodule

/* bench/batchFilterTb.sv */
`timescale 1ns/1ns
`include "batch_config.svh"

module batchFilterTb import batchPkg::*; ();

    localparam int depth = `BATCH_DEPTH;
    localparam int dsr = `BATCH_DSR;
    localparam int latency = 2 * `BATCH_DEPTH + 4;
    localparam int maxRows = 10;

    typedef enum {ONES, ZEROS, ALTERNATE, RANDOM} stimKindT;

    logic clkDS, rst, run, cfgWrite;
    streamWordT inWord;
    logic [2:0] cfgAddr;
    weightT cfgData;
    outT outData;
    logic outValid;

    // Test table, one entry per row
    string rowName [maxRows];
    int rowBatches [maxRows];
    stimKindT rowKind [maxRows];
    int rowStopAt [maxRows];
    int rowCfgCount [maxRows];
    logic [2:0] rowCfgAddr [maxRows][8];
    weightT rowCfgData [maxRows][8];
    int numRows;
    bit tableReady;

    // Reference model state follows every configuration write
    weightT modelWeights [dsr];
    shiftT modelShift;
    streamWordT words[$];
    outT expected[$];
    int errors;
    int checks;

    batchFilterTop dut0 (
        .clkDS(clkDS), .rst(rst), .run(run), .inWord(inWord),
        .cfgWrite(cfgWrite), .cfgAddr(cfgAddr), .cfgData(cfgData),
        .outData(outData), .outValid(outValid)
    );

    initial begin
        clkDS = 1'b0;
        forever #4 clkDS = ~clkDS;
    end

    function automatic void addRow(string name, int batches, stimKindT kind, int stopAt);
        rowName[numRows] = name;
        rowBatches[numRows] = batches;
        rowKind[numRows] = kind;
        rowStopAt[numRows] = stopAt;
        rowCfgCount[numRows] = 0;
        numRows++;
    endfunction

    // Appends a register write to the most recent row
    function automatic void addCfg(int addr, int data);
        rowCfgAddr[numRows - 1][rowCfgCount[numRows - 1]] = 3'(addr);
        rowCfgData[numRows - 1][rowCfgCount[numRows - 1]] = weightT'(data);
        rowCfgCount[numRows - 1]++;
    endfunction

    function automatic void fillTable();
        addRow("defaults all ones", 2, ONES, 0);
        addRow("defaults all zeros", 2, ZEROS, 0);
        addRow("defaults random", 4, RANDOM, 0);
        addRow("defaults alternating", 3, ALTERNATE, 0);
        addRow("new taps and decay", 3, RANDOM, 0);
        addCfg(0, 1);
        addCfg(1, -3);
        addCfg(2, 7);
        addCfg(3, 12);
        addCfg(4, -9);
        addCfg(5, 5);
        addCfg(6, 1);
        // Run drops while batch 0 drains
        addRow("run drop mid stream", 2, RANDOM, depth + latency);
        addRow("restart after drop", 3, RANDOM, 0);
        addCfg(6, 4);
        addCfg(7, 9);
        addRow("extreme positive taps", 2, ONES, 0);
        for (int i = 0; i < dsr; i++) begin
            addCfg(i, 31);
        end
        addCfg(6, 7);
        addRow("extreme negative taps", 2, ONES, 0);
        for (int i = 0; i < dsr; i++) begin
            addCfg(i, -32);
        end
    endfunction

    function automatic streamWordT makeWord(stimKindT kind, int idx);
        streamWordT w;
        w = '0;
        case (kind)
            ONES: w = '1;
            ZEROS: w = '0;
            ALTERNATE: begin
                for (int i = 0; i < dsr; i++) begin
                    w[i] = ((i + idx) % 2) == 1;
                end
            end
            default: w = streamWordT'($urandom);
        endcase
        return w;
    endfunction

    // Set bit adds its weight, clear bit subtracts it
    function automatic int lookupValue(streamWordT word);
        int sum;
        sum = 0;
        for (int i = 0; i < dsr; i++) begin
            sum = word[i] ? sum + int'(modelWeights[i]) : sum - int'(modelWeights[i]);
        end
        return sum;
    endfunction

    function automatic outT toOffsetBinary(int sum);
        int maxVal;
        int clamped;
        outT y;
        maxVal = (1 << (`BATCH_OUT_W - 1)) - 1;
        if (sum > maxVal) begin
            clamped = maxVal;
        end else if (sum < -maxVal - 1) begin
            clamped = -maxVal - 1;
        end else begin
            clamped = sum;
        end
        y = outT'(clamped);
        y[`BATCH_OUT_W-1] = ~y[`BATCH_OUT_W-1];
        return y;
    endfunction

    // Both recursions restart from zero in every batch
    function automatic void buildExpected(int batches);
        int x [depth];
        int fwd [depth];
        int bwd [depth];
        int s;
        for (int b = 0; b < batches; b++) begin
            for (int j = 0; j < depth; j++) begin
                x[j] = lookupValue(words[b * depth + j]);
            end
            s = 0;
            for (int j = 0; j < depth; j++) begin
                s = s - (s >>> modelShift) + x[j];
                fwd[j] = s;
            end
            s = 0;
            for (int j = depth - 1; j >= 0; j--) begin
                s = s - (s >>> modelShift) + x[j];
                bwd[j] = s;
            end
            for (int j = 0; j < depth; j++) begin
                expected.push_back(toOffsetBinary(fwd[j] + bwd[j]));
            end
        end
    endfunction

    task automatic writeConfig(logic [2:0] addr, weightT data);
        @(negedge clkDS);
        cfgWrite = 1'b1;
        cfgAddr = addr;
        cfgData = data;
        @(negedge clkDS);
        cfgWrite = 1'b0;
        if (int'(addr) < dsr) begin
            modelWeights[addr] = data;
        end else if (int'(addr) == dsr) begin
            modelShift = data[2:0];
        end
    endtask

    task automatic runRow(int r);
        int endAt;
        int rowErrors;
        int rowChecks;
        logic expValid;
        outT want;
        rowErrors = 0;
        rowChecks = 0;
        for (int c = 0; c < rowCfgCount[r]; c++) begin
            writeConfig(rowCfgAddr[r][c], rowCfgData[r][c]);
        end
        repeat (2) @(negedge clkDS);
        endAt = (rowStopAt[r] != 0) ? rowStopAt[r] : rowBatches[r] * depth + latency;
        words.delete();
        expected.delete();
        for (int i = 0; i < endAt; i++) begin
            words.push_back(makeWord(rowKind[r], i));
        end
        buildExpected(rowBatches[r]);
        // Output seen at falling edge i left the pipeline at the edge before
        for (int i = 0; i <= endAt; i++) begin
            @(negedge clkDS);
            expValid = (i > latency);
            assert (outValid === expValid) else begin
                $display("FAIL %s cycle %0d: outValid=0x%h expected=0x%h",
                    rowName[r], i, outValid, expValid);
                rowErrors++;
            end
            if (expValid) begin
                want = expected[i - latency - 1];
                rowChecks++;
                assert (outData === want) else begin
                    $display("FAIL %s word %0d: outData=0x%h expected=0x%h",
                        rowName[r], i - latency - 1, outData, want);
                    rowErrors++;
                end
            end
            run = (i < endAt);
            inWord = (i < endAt) ? words[i] : '0;
        end
        @(negedge clkDS);
        assert (outValid === 1'b0) else begin
            $display("FAIL %s after run drop: outValid=0x%h expected=0x0", rowName[r], outValid);
            rowErrors++;
        end
        $display("row %0d %s: %0d words checked, %0d errors", r, rowName[r], rowChecks,
            rowErrors);
        errors += rowErrors;
        checks += rowChecks;
    endtask

    initial begin
        rst = 1'b0;
        run = 1'b0;
        inWord = '0;
        cfgWrite = 1'b0;
        cfgAddr = '0;
        cfgData = '0;
        errors = 0;
        checks = 0;
        numRows = 0;
        void'($urandom(32'hdbaf_6a69));
        for (int i = 0; i < dsr; i++) begin
            modelWeights[i] = weightT'(`BATCH_WEIGHT_DEF);
        end
        modelShift = shiftT'(`BATCH_DECAY_DEF);
        fillTable();
        tableReady = 1'b1;
        repeat (10) @(negedge clkDS);
        rst = 1'b1;
        for (int r = 0; r < numRows; r++) begin
            runRow(r);
        end
        $display("Summary: %0d rows, %0d words checked, %0d errors", numRows, checks, errors);
        if (errors == 0) begin
            $display("Test passed");
        end else begin
            $display("Test failed");
        end
        $finish;
    end

    // Watchdog sized from the table
    initial begin
        int limit;
        wait (tableReady);
        limit = 10 + 64;
        for (int r = 0; r < numRows; r++) begin
            limit += (rowBatches[r] + 3) * depth + 24;
        end
        repeat (limit) @(posedge clkDS);
        $display("Timeout: the run did not finish within %0d clock cycles", limit);
        $display("Test failed");
        $finish;
    end

endmodule

/* src.f */
+incdir+include
source/batchPkg.sv
source/batchSequencer.sv
source/sampleStore.sv
source/coeffRegs.sv
source/tapLookup.sv
source/recursionUnit.sv
source/partialStore.sv
source/resultCombiner.sv
source/batchFilterTop.sv
bench/batchFilterTb.sv

/* Makefile */
VERILATOR ?= verilator
TOP ?= batchFilterTb
FILELIST ?= src.f
BUILD_DIR ?= obj_dir
LOG ?= sim.log
VFLAGS ?= --binary --timing --assert -j 0

SOURCES := $(filter-out +%,$(shell cat $(FILELIST)))
HEADERS := $(wildcard include/*.svh)
BIN := $(BUILD_DIR)/V$(TOP)

.PHONY: all build run check clean

all: run

build: $(BIN)

$(BIN): $(SOURCES) $(HEADERS) $(FILELIST)
	$(VERILATOR) $(VFLAGS) -f $(FILELIST) --top-module $(TOP) --Mdir $(BUILD_DIR) -o V$(TOP)

run: $(BIN)
	$(BIN) > $(LOG) 2>&1; cat $(LOG)
	@$(MAKE) --no-print-directory check LOG=$(LOG)

check:
	@grep -qx 'Test passed' $(LOG) || { echo "No pass line found in $(LOG)"; exit 1; }

clean:
	rm -rf $(BUILD_DIR) $(LOG)
